// File: hdl/vc_router_pkg.sv
package vc_router_pkg;

  // ==========================================================================
  // router limits
  // ==========================================================================

  // largest port count the header field can address
  localparam int MaxPorts = 8;
  // largest number of virtual channels per port
  localparam int MaxVc    = 4;

  // ==========================================================================
  // flit format
  // ==========================================================================

  // destination output port index
  typedef logic [$clog2(MaxPorts)-1:0] port_id_t;
  // virtual channel id, kept unchanged from input to output
  typedef logic [$clog2(MaxVc)-1:0]    vc_id_t;
  // flit data
  typedef logic [31:0]                 payload_t;

  // header sits in the upper bits of the flit
  typedef struct packed {
    port_id_t dst_port;
    vc_id_t   vc_id;
  } flit_hdr_t;

  // full flit, header then payload
  typedef struct packed {
    flit_hdr_t hdr;
    payload_t  payload;
  } flit_t;

endpackage

// File: hdl/vc_head_if.sv
interface vc_head_if import vc_router_pkg::*; #(
  parameter int NumVc = 2
);

  // one head per virtual channel FIFO
  logic  [NumVc-1:0] head_v;
  flit_t [NumVc-1:0] head_flit;

  // pop request from the switch allocator
  // pop_vc must name a VC whose head_v is set
  logic              pop_v;
  vc_id_t            pop_vc;

  // input port side, presents heads and takes pops
  modport port (
    output head_v,
    output head_flit,
    input  pop_v,
    input  pop_vc
  );

  // allocator side, reads heads and pops the winner
  modport alloc (
    input  head_v,
    input  head_flit,
    output pop_v,
    output pop_vc
  );

endinterface

// File: hdl/vc_input_port.sv
module vc_input_port import vc_router_pkg::*; #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  // flits from the upstream sender
  input  logic   data_v_i,
  input  flit_t  data_i,
  // one credit back per flit that leaves
  output logic   credit_v_o,
  output vc_id_t credit_id_o,
  // heads towards the allocator
  vc_head_if.port head,
  // popped flit towards switch traversal
  output flit_t  pop_flit_o
);

  localparam int PtrW = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CntW = $clog2(VcDepth + 1);

  // per-VC circular buffers
  flit_t [NumVc-1:0][VcDepth-1:0] mem_q;
  logic  [NumVc-1:0][PtrW-1:0]    wr_ptr_q;
  logic  [NumVc-1:0][PtrW-1:0]    rd_ptr_q;
  logic  [NumVc-1:0][CntW-1:0]    count_q;
  logic  [NumVc-1:0]              wr_en;
  logic  [NumVc-1:0]              rd_en;
  logic  [NumVc-1:0]              full;
  flit_t [NumVc-1:0]              head_flit;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(VcDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // decode write and pop per VC, expose heads
  always_comb begin
    for (int v = 0; v < NumVc; v++) begin
      wr_en[v]          = data_v_i && (data_i.hdr.vc_id == vc_id_t'(v));
      rd_en[v]          = head.pop_v && (head.pop_vc == vc_id_t'(v));
      full[v]           = (count_q[v] == CntW'(VcDepth));
      head.head_v[v]    = (count_q[v] != '0);
      head_flit[v]      = mem_q[v][rd_ptr_q[v]];
    end
  end

  assign head.head_flit = head_flit;

  // head of the popped VC goes straight to the output register
  always_comb begin
    pop_flit_o = head_flit[0];
    for (int v = 1; v < NumVc; v++) begin
      if (head.pop_vc == vc_id_t'(v)) begin
        pop_flit_o = head_flit[v];
      end
    end
  end

  // flit storage
  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NumVc; v++) begin
      if (wr_en[v]) begin
        mem_q[v][wr_ptr_q[v]] <= data_i;
      end
    end
  end

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        if (wr_en[v]) begin
          wr_ptr_q[v] <= next_ptr(wr_ptr_q[v]);
        end
        if (rd_en[v]) begin
          rd_ptr_q[v] <= next_ptr(rd_ptr_q[v]);
        end
        if (wr_en[v] && !rd_en[v]) begin
          count_q[v] <= count_q[v] + 1'b1;
        end else if (rd_en[v] && !wr_en[v]) begin
          count_q[v] <= count_q[v] - 1'b1;
        end
      end
    end
  end

  // credit pulse, one cycle after the pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_v_o <= 1'b0;
    end else begin
      credit_v_o <= head.pop_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (head.pop_v) begin
      credit_id_o <= head.pop_vc;
    end
  end

  // sender only writes with a credit in hand, so the VC exists and has room
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_v_i |-> (|wr_en) && !(|(wr_en & full)));

endmodule

// File: hdl/sa_local.sv
module sa_local import vc_router_pkg::*; #(
  parameter int NumPorts = 3,
  parameter int NumVc    = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  vc_head_if.alloc                      head,
  // downstream credit state of every output, per VC
  input  logic [NumPorts-1:0][NumVc-1:0] credit_avail_i,
  // request towards the global stage
  output logic                          req_v_o,
  output port_id_t                      req_port_o,
  output vc_id_t                        req_vc_o,
  input  logic                          granted_i
);

  logic [NumVc-1:0] vc_req;
  vc_id_t           rr_ptr_q;
  logic             sel_v;
  vc_id_t           sel_vc;

  // a VC competes only with a head and a credit at its destination
  always_comb begin
    for (int v = 0; v < NumVc; v++) begin
      vc_req[v] = 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        if (head.head_flit[v].hdr.dst_port == port_id_t'(p)) begin
          vc_req[v] = head.head_v[v] && credit_avail_i[p][v];
        end
      end
    end
  end

  // round-robin search starting at the pointer
  always_comb begin
    int idx;
    sel_v  = 1'b0;
    sel_vc = '0;
    for (int i = 0; i < NumVc; i++) begin
      idx = int'(rr_ptr_q) + i;
      if (idx >= NumVc) begin
        idx = idx - NumVc;
      end
      if (!sel_v && vc_req[idx]) begin
        sel_v  = 1'b1;
        sel_vc = vc_id_t'(idx);
      end
    end
  end

  // destination of the chosen head
  always_comb begin
    req_port_o = head.head_flit[0].hdr.dst_port;
    for (int v = 1; v < NumVc; v++) begin
      if (sel_vc == vc_id_t'(v)) begin
        req_port_o = head.head_flit[v].hdr.dst_port;
      end
    end
  end

  assign req_v_o  = sel_v;
  assign req_vc_o = sel_vc;

  // a grant pops the chosen VC
  assign head.pop_v  = granted_i && sel_v;
  assign head.pop_vc = sel_vc;

  // pointer moves past the winner only when it actually went
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (granted_i) begin
      rr_ptr_q <= (sel_vc == vc_id_t'(NumVc - 1)) ? '0 : sel_vc + 1'b1;
    end
  end

endmodule

// File: hdl/sa_global.sv
module sa_global import vc_router_pkg::*; #(
  parameter int NumPorts = 3
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // one request bit per input port
  input  logic [NumPorts-1:0] req_i,
  // one-hot winner, zero when idle
  output logic [NumPorts-1:0] gnt_o
);

  port_id_t rr_ptr_q;
  port_id_t win;
  logic     any_gnt;

  // round-robin over inputs, first requester from the pointer wins
  always_comb begin
    int idx;
    gnt_o   = '0;
    win     = '0;
    any_gnt = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      idx = int'(rr_ptr_q) + i;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!any_gnt && req_i[idx]) begin
        any_gnt    = 1'b1;
        gnt_o[idx] = 1'b1;
        win        = port_id_t'(idx);
      end
    end
  end

  // advance past the winner
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (any_gnt) begin
      rr_ptr_q <= (win == port_id_t'(NumPorts - 1)) ? '0 : win + 1'b1;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  // at most one input per output and cycle, only requesters, no idle with work
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0) && ((|req_i) == (|gnt_o)));

endmodule

// File: hdl/vc_output_port.sv
module vc_output_port import vc_router_pkg::*; #(
  parameter int NumPorts = 3,
  parameter int NumVc    = 2,
  parameter int VcDepth  = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // winner of the global stage, one-hot over inputs
  input  logic  [NumPorts-1:0] gnt_i,
  input  flit_t [NumPorts-1:0] in_flits_i,
  // credits back from the downstream receiver
  input  logic                 credit_v_i,
  input  vc_id_t               credit_id_i,
  output logic  [NumVc-1:0]    credit_avail_o,
  // switch traversal register
  output logic                 data_v_o,
  output flit_t                data_o
);

  localparam int CntW = $clog2(VcDepth + 1);

  flit_t                      sel_flit;
  logic                       any_gnt;
  logic [NumVc-1:0]           dec;
  logic [NumVc-1:0]           inc;
  logic [NumVc-1:0][CntW-1:0] credit_q;

  // crossbar column
  always_comb begin
    sel_flit = in_flits_i[0];
    for (int i = 1; i < NumPorts; i++) begin
      if (gnt_i[i]) begin
        sel_flit = in_flits_i[i];
      end
    end
  end

  assign any_gnt = |gnt_i;

  // a sent flit takes a credit, a returned credit gives one back
  always_comb begin
    for (int v = 0; v < NumVc; v++) begin
      dec[v]            = any_gnt && (sel_flit.hdr.vc_id == vc_id_t'(v));
      inc[v]            = credit_v_i && (credit_id_i == vc_id_t'(v));
      credit_avail_o[v] = (credit_q[v] != '0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVc; v++) begin
        credit_q[v] <= CntW'(VcDepth);
      end
      data_v_o <= 1'b0;
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        if (inc[v] && !dec[v]) begin
          credit_q[v] <= credit_q[v] + 1'b1;
        end else if (dec[v] && !inc[v]) begin
          credit_q[v] <= credit_q[v] - 1'b1;
        end
      end
      data_v_o <= any_gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      data_o <= sel_flit;
    end
  end

  // ==========================================================================
  // credit range per VC
  // ==========================================================================

  for (genvar v = 0; v < NumVc; v++) begin : gen_credit_chk
    // allocator never sends without a credit
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dec[v] |-> credit_q[v] != '0);
    // receiver never returns more than it was sent
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (inc[v] && !dec[v]) |-> credit_q[v] < CntW'(VcDepth));
  end

endmodule

// File: hdl/vc_router.sv
module vc_router import vc_router_pkg::*; #(
  parameter int NumPorts = 3,
  parameter int NumVc    = 2,
  parameter int VcDepth  = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // upstream side
  input  logic   [NumPorts-1:0] data_v_i,
  input  flit_t  [NumPorts-1:0] data_i,
  output logic   [NumPorts-1:0] credit_v_o,
  output vc_id_t [NumPorts-1:0] credit_id_o,
  // downstream side
  output logic   [NumPorts-1:0] data_v_o,
  output flit_t  [NumPorts-1:0] data_o,
  input  logic   [NumPorts-1:0] credit_v_i,
  input  vc_id_t [NumPorts-1:0] credit_id_i
);

  if (NumPorts > MaxPorts || NumVc > MaxVc) begin : gen_limit_err
    $error("vc_router: NumPorts or NumVc beyond header field range");
  end

  vc_head_if #(.NumVc(NumVc)) head_if [NumPorts] ();

  flit_t    [NumPorts-1:0]               pop_flit;
  // indexed by output, then VC
  logic     [NumPorts-1:0][NumVc-1:0]    credit_avail;
  logic     [NumPorts-1:0]               req_v;
  port_id_t [NumPorts-1:0]               req_port;
  logic     [NumPorts-1:0]               granted;
  // indexed by output, then input
  logic     [NumPorts-1:0][NumPorts-1:0] req_per_out;
  logic     [NumPorts-1:0][NumPorts-1:0] gnt_per_out;

  // ==========================================================================
  // request and grant regrouping
  // ==========================================================================

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        req_per_out[o][i] = req_v[i] && (req_port[i] == port_id_t'(o));
      end
    end
  end

  // each input wins at most one output, since it asks for only one
  always_comb begin
    granted = '0;
    for (int o = 0; o < NumPorts; o++) begin
      granted = granted | gnt_per_out[o];
    end
  end

  // ==========================================================================
  // per-port stages
  // ==========================================================================

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    vc_input_port #(
      .NumVc   (NumVc),
      .VcDepth (VcDepth)
    ) u_input_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .head        (head_if[p]),
      .pop_flit_o  (pop_flit[p])
    );

    // the chosen VC reaches the input port through the pop on head_if
    sa_local #(
      .NumPorts (NumPorts),
      .NumVc    (NumVc)
    ) u_sa_local (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .head           (head_if[p]),
      .credit_avail_i (credit_avail),
      .req_v_o        (req_v[p]),
      .req_port_o     (req_port[p]),
      .req_vc_o       (),
      .granted_i      (granted[p])
    );

    sa_global #(
      .NumPorts (NumPorts)
    ) u_sa_global (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (req_per_out[p]),
      .gnt_o   (gnt_per_out[p])
    );

    vc_output_port #(
      .NumPorts (NumPorts),
      .NumVc    (NumVc),
      .VcDepth  (VcDepth)
    ) u_output_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .gnt_i          (gnt_per_out[p]),
      .in_flits_i     (pop_flit),
      .credit_v_i     (credit_v_i[p]),
      .credit_id_i    (credit_id_i[p]),
      .credit_avail_o (credit_avail[p]),
      .data_v_o       (data_v_o[p]),
      .data_o         (data_o[p])
    );
  end

endmodule

// File: tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==========================================================================
// error exits
// ==========================================================================

// first error ends the run
task automatic stop_on_error();
  $display("TESTBENCH FAILED");
  $fatal(1, "simulation stopped on first error");
endtask

task automatic report_timeout(string what);
  $display("timed out waiting for %s", what);
  stop_on_error();
endtask

// ==========================================================================
// typed compares
// ==========================================================================

task automatic check_flit(string name, flit_t got, flit_t exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_vc(string name, vc_id_t got, vc_id_t exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_count(string name, int got, int exp);
  if (got != exp) begin
    $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
    stop_on_error();
  end
endtask

`endif

// File: tests/tb_vc_router.sv
module tb_vc_router import vc_router_pkg::*; ();

  localparam int NumPorts      = 3;
  localparam int NumVc         = 2;
  localparam int VcDepth       = 2;
  localparam int NumKeys       = NumPorts * NumVc;
  localparam int NumRows       = 17;
  localparam int TimeoutCycles = 500;
  // output 2, VC 1 is the channel whose downstream credits get held
  localparam int HeldKey       = 2 * NumVc + 1;
  // idle stretch on the held output before its credits come back
  localparam int HoldCycles    = 16;

  typedef struct packed {
    int       in_port;
    int       dst;
    int       vc;
    payload_t payload;
    bit       hold;
  } row_t;

  // expected flit plus the input it came from
  typedef struct packed {
    int    src;
    flit_t flit;
  } exp_t;

  // ==========================================================================
  // stimulus table
  // ==========================================================================

  // payload top nibble names the sending input
  localparam row_t Rows [NumRows] = '{
    // three inputs fight for output 1
    '{0, 1, 0, 32'h0000_0101, 1'b0},
    '{1, 1, 0, 32'h1000_0102, 1'b0},
    '{2, 1, 0, 32'h2000_0103, 1'b0},
    '{0, 1, 0, 32'h0000_0104, 1'b0},
    '{1, 1, 1, 32'h1000_0105, 1'b0},
    '{2, 1, 0, 32'h2000_0106, 1'b0},
    '{0, 2, 0, 32'h0000_0107, 1'b0},
    '{1, 0, 1, 32'h1000_0108, 1'b0},
    '{2, 0, 0, 32'h2000_0109, 1'b0},
    // output 2 VC 1 gets no credits back until released
    '{0, 2, 1, 32'h0000_0201, 1'b1},
    '{0, 2, 1, 32'h0000_0202, 1'b1},
    '{0, 2, 1, 32'h0000_0203, 1'b1},
    '{0, 2, 1, 32'h0000_0204, 1'b1},
    // VC 0 must still get through to output 2
    '{0, 2, 0, 32'h0000_0205, 1'b0},
    '{1, 2, 0, 32'h1000_0206, 1'b0},
    '{2, 2, 1, 32'h2000_0207, 1'b1},
    '{1, 2, 0, 32'h1000_0208, 1'b0}
  };

  logic                  clk_i;
  logic                  rst_n_i;
  logic   [NumPorts-1:0] data_v_i;
  flit_t  [NumPorts-1:0] data_i;
  logic   [NumPorts-1:0] credit_v_o;
  vc_id_t [NumPorts-1:0] credit_id_o;
  logic   [NumPorts-1:0] data_v_o;
  flit_t  [NumPorts-1:0] data_o;
  logic   [NumPorts-1:0] credit_v_i;
  vc_id_t [NumPorts-1:0] credit_id_i;

  // scoreboard, one queue per output and VC
  exp_t   exp_q [NumKeys][$];
  int     delivered [NumKeys];
  // downstream side, credits already handed back and held channels
  int     ds_returned [NumKeys];
  bit     held [NumKeys];
  // upstream credit bookkeeping per input and VC
  int     sent_cnt [NumPorts][NumVc];
  int     ret_cnt [NumPorts][NumVc];
  integer seed = 32'haeb1_d853;

  `include "tb_checks.svh"

  vc_router #(
    .NumPorts (NumPorts),
    .NumVc    (NumVc),
    .VcDepth  (VcDepth)
  ) u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic flit_t make_flit(int dst, int vc, payload_t payload);
    flit_t f;
    f.hdr.dst_port = port_id_t'(dst);
    f.hdr.vc_id    = vc_id_t'(vc);
    f.payload      = payload;
    return f;
  endfunction

  // flits still expected, skipping one output and VC (-1 skips none)
  function automatic int queued_except(int skip_key);
    int n;
    n = 0;
    for (int k = 0; k < NumKeys; k++) begin
      if (k != skip_key) begin
        n += exp_q[k].size();
      end
    end
    return n;
  endfunction

  // one flit per call, only with an upstream credit in hand
  task automatic send_flit(int src, int dst, int vc, payload_t payload);
    exp_t e;
    int   t;
    t = 0;
    @(posedge clk_i);
    data_v_i <= '0;
    while (VcDepth - (sent_cnt[src][vc] - ret_cnt[src][vc]) == 0) begin
      t++;
      if (t > TimeoutCycles) begin
        report_timeout($sformatf("an upstream credit on input %0d", src));
      end
      @(posedge clk_i);
    end
    e.src  = src;
    e.flit = make_flit(dst, vc, payload);
    data_v_i[src] <= 1'b1;
    data_i[src]   <= e.flit;
    sent_cnt[src][vc]++;
    exp_q[dst * NumVc + vc].push_back(e);
  endtask

  task automatic release_inputs();
    @(posedge clk_i);
    data_v_i <= '0;
  endtask

  task automatic wait_drain(int skip_key, string what);
    int t;
    t = 0;
    while (queued_except(skip_key) != 0) begin
      t++;
      if (t > TimeoutCycles) begin
        report_timeout(what);
      end
      @(posedge clk_i);
    end
  endtask

  // ==========================================================================
  // output monitor and credit check
  // ==========================================================================

  // a pop registers the flit and the credit pulse at the same edge
  initial begin : monitor
    int     src;
    int     key;
    int     idx;
    int     exp_cv [NumPorts];
    vc_id_t exp_cid [NumPorts];
    flit_t  got;
    forever begin
      @(negedge clk_i);
      if (rst_n_i) begin
        for (int p = 0; p < NumPorts; p++) begin
          exp_cv[p]  = 0;
          exp_cid[p] = '0;
        end
        for (int o = 0; o < NumPorts; o++) begin
          if (data_v_o[o]) begin
            got = data_o[o];
            src = int'(got.payload[31:28]);
            key = o * NumVc + int'(got.hdr.vc_id);
            idx = -1;
            if (int'(got.hdr.vc_id) >= NumVc) begin
              $display("output %0d sent a flit on a VC that does not exist", o);
              stop_on_error();
            end
            // oldest flit from the same input must come first
            for (int k = 0; k < exp_q[key].size(); k++) begin
              if (idx < 0 && exp_q[key][k].src == src) begin
                idx = k;
              end
            end
            if (idx < 0) begin
              $display("output %0d sent a flit that was never sent in or came twice", o);
              stop_on_error();
            end
            check_flit($sformatf("data_o[%0d]", o), got, exp_q[key][idx].flit);
            exp_cv[exp_q[key][idx].src]++;
            exp_cid[exp_q[key][idx].src] = exp_q[key][idx].flit.hdr.vc_id;
            exp_q[key].delete(idx);
            delivered[key]++;
          end
        end
        for (int p = 0; p < NumPorts; p++) begin
          check_count($sformatf("credit_v_o[%0d]", p), int'(credit_v_o[p]), exp_cv[p]);
          if (credit_v_o[p]) begin
            check_vc($sformatf("credit_id_o[%0d]", p), credit_id_o[p], exp_cid[p]);
            ret_cnt[p][int'(credit_id_o[p])]++;
          end
        end
      end
    end
  end

  // ==========================================================================
  // downstream receiver
  // ==========================================================================

  // random gate per output gives each credit a random delay
  initial begin : downstream
    int rnd;
    int sel;
    int key;
    credit_v_i  = '0;
    credit_id_i = '0;
    forever begin
      @(posedge clk_i);
      for (int o = 0; o < NumPorts; o++) begin
        rnd = $random(seed);
        sel = -1;
        if (rnd[1:0] != 2'b11) begin
          for (int v = 0; v < NumVc; v++) begin
            key = o * NumVc + v;
            if (sel < 0 && !held[key] && delivered[key] > ds_returned[key]) begin
              sel = v;
            end
          end
        end
        if (sel >= 0) begin
          credit_v_i[o]  <= 1'b1;
          credit_id_i[o] <= vc_id_t'(sel);
          ds_returned[o * NumVc + sel]++;
        end else begin
          credit_v_i[o] <= 1'b0;
        end
      end
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin : main
    flit_t single;
    rst_n_i   = 1'b0;
    data_v_i  = '0;
    data_i    = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // no input, so nothing may move
    repeat (4) begin
      @(negedge clk_i);
      check_count("data_v_o", int'(data_v_o), 0);
      check_count("credit_v_o", int'(credit_v_o), 0);
    end

    // lone flit, taken in at the next edge, switched at the one after
    single = make_flit(1, 0, 32'h0000_00a1);
    send_flit(0, 1, 0, 32'h0000_00a1);
    release_inputs();
    @(negedge clk_i);
    check_count("data_v_o[1]", int'(data_v_o[1]), 0);
    @(negedge clk_i);
    check_count("data_v_o[1]", int'(data_v_o[1]), 1);
    check_flit("data_o[1]", data_o[1], single);
    wait_drain(-1, "the single flit to leave");

    for (int r = 0; r < NumRows; r++) begin
      if (Rows[r].hold) begin
        held[Rows[r].dst * NumVc + Rows[r].vc] = 1'b1;
      end
      send_flit(Rows[r].in_port, Rows[r].dst, Rows[r].vc, Rows[r].payload);
    end
    release_inputs();

    // held channel stops after its downstream credits run out
    wait_drain(HeldKey, "the flits on channels with credit");
    check_count("delivered on held VC", delivered[HeldKey], VcDepth);

    // other VC drained, held VC out of credit, so the output stays idle
    repeat (HoldCycles) begin
      @(negedge clk_i);
      check_count($sformatf("data_v_o[%0d]", HeldKey / NumVc),
                  int'(data_v_o[HeldKey / NumVc]), 0);
    end

    for (int k = 0; k < NumKeys; k++) begin
      held[k] = 1'b0;
    end
    wait_drain(-1, "the flits of the released VC");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+tests
hdl/vc_router_pkg.sv
hdl/vc_head_if.sv
hdl/vc_input_port.sv
hdl/sa_local.sv
hdl/sa_global.sv
hdl/vc_output_port.sv
hdl/vc_router.sv
tests/tb_vc_router.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vc_router
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
